//--- core_pkg.sv
package core_pkg;

    ////////////////////
    // Widths and words
    ////////////////////

    // Datapath width, RV32
    localparam int unsigned xlen = 32;

    // Operands, results, immediates
    typedef logic [xlen-1:0] data_t;

    // Raw instruction word
    typedef logic [31:0] inst_t;

    // Architectural register index, wide enough for RV32I
    typedef logic [4:0] reg_idx_t;

    // Instruction fields
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    ////////////////////
    // Encodings
    ////////////////////

    // Major opcodes kept by this core, anything else is illegal
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op_reg = 7'b0110011,
        op_lui = 7'b0110111
    } opcode_e;

    // ALU functions
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b    // operand B straight through, for LUI
    } alu_func_e;

endpackage

//--- core_if.sv
`timescale 1ns/10ps

// Decode to execute, one decoded instruction
interface dec_exe_if;
    logic                  valid;
    logic                  illegal;
    core_pkg::alu_func_e   func;
    core_pkg::reg_idx_t    rs1;
    core_pkg::reg_idx_t    rs2;
    logic                  use_imm;
    core_pkg::data_t       imm;
    logic                  write_rd;    // Already false for x0 and illegal words
    core_pkg::reg_idx_t    rd;

    modport producer (output valid, illegal, func, rs1, rs2, use_imm, imm, write_rd, rd);
    modport consumer (input valid, illegal, func, rs1, rs2, use_imm, imm, write_rd, rd);
endinterface

// Execute to result, one executed instruction
interface exe_res_if;
    logic                  valid;
    logic                  illegal;
    logic                  write_rd;
    core_pkg::reg_idx_t    rd;
    core_pkg::data_t       value;

    modport producer (output valid, illegal, write_rd, rd, value);
    modport consumer (input valid, illegal, write_rd, rd, value);
endinterface

// Two combinational register file read ports
interface reg_read_if;
    core_pkg::reg_idx_t    rs1;
    core_pkg::reg_idx_t    rs2;
    core_pkg::data_t       rs1_data;
    core_pkg::data_t       rs2_data;

    modport requester (output rs1, rs2, input rs1_data, rs2_data);
    modport provider (input rs1, rs2, output rs1_data, rs2_data);
endinterface

//--- inst_decode.sv
`timescale 1ns/10ps

module inst_decode #(
    parameter int num_regs = 32
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  core_pkg::inst_t     inst,
    dec_exe_if.producer         dec
);

    // Field split
    logic [6:0]              opcode;
    core_pkg::funct3_t       funct3;
    core_pkg::funct7_t       funct7;
    core_pkg::reg_idx_t      rs1;
    core_pkg::reg_idx_t      rs2;
    core_pkg::reg_idx_t      rd;

    // Decoded controls
    core_pkg::alu_func_e     func;
    logic                    use_imm;
    core_pkg::data_t         imm;
    logic                    uses_rs1;
    logic                    uses_rs2;
    logic                    known_op;
    logic                    bad_funct7;
    logic                    bad_index;
    logic                    illegal;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    // funct3 to ALU function, alt picks SUB / SRA
    function automatic core_pkg::alu_func_e base_func(core_pkg::funct3_t f3, logic alt);
        core_pkg::alu_func_e f;
        case (f3)
            3'b000:  f = alt ? core_pkg::alu_sub : core_pkg::alu_add;
            3'b001:  f = core_pkg::alu_sll;
            3'b010:  f = core_pkg::alu_slt;
            3'b011:  f = core_pkg::alu_sltu;
            3'b100:  f = core_pkg::alu_xor;
            3'b101:  f = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
            3'b110:  f = core_pkg::alu_or;
            default: f = core_pkg::alu_and;
        endcase
        return f;
    endfunction

    ////////////////////
    // Decode
    ////////////////////

    always_comb begin
        func       = core_pkg::alu_add;
        use_imm    = 1'b0;
        imm        = '0;
        uses_rs1   = 1'b0;
        uses_rs2   = 1'b0;
        known_op   = 1'b1;
        bad_funct7 = 1'b0;
        case (opcode)
            core_pkg::op_reg: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                func     = base_func(funct3, funct7[5]);
                // Alternate encoding only on ADD/SUB and SRL/SRA
                if (funct7 == 7'b0100000) begin
                    bad_funct7 = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else begin
                    bad_funct7 = (funct7 != 7'b0000000);
                end
            end
            core_pkg::op_imm: begin
                uses_rs1 = 1'b1;
                use_imm  = 1'b1;
                imm      = {{20{inst[31]}}, inst[31:20]};
                // No SUBI, alt bit only counts for shifts right
                func     = base_func(funct3, (funct3 == 3'b101) && funct7[5]);
                if (funct3 == 3'b001) begin
                    bad_funct7 = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    bad_funct7 = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            core_pkg::op_lui: begin
                use_imm = 1'b1;
                imm     = {inst[31:12], 12'b0};
                func    = core_pkg::alu_pass_b;
            end
            default: known_op = 1'b0;
        endcase
    end

    // Index range check, matters for the 16 register variant
    assign bad_index = (uses_rs1 && (rs1 >= num_regs))
                     || (uses_rs2 && (rs2 >= num_regs))
                     || (rd >= num_regs);

    assign illegal = !known_op || bad_funct7 || bad_index;

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= inst_valid;
        end
    end

    always_ff @(posedge clock) begin
        dec.illegal  <= illegal;
        dec.func     <= func;
        dec.rs1      <= rs1;
        dec.rs2      <= rs2;
        dec.use_imm  <= use_imm;
        dec.imm      <= imm;
        dec.rd       <= rd;
        // No write for x0 or illegal words
        dec.write_rd <= !illegal && (rd != '0);
    end

endmodule

//--- alu_execute.sv
`timescale 1ns/10ps

module alu_execute (
    input  logic            clock,
    input  logic            rst_n,
    dec_exe_if.consumer     dec,
    reg_read_if.requester   rd_port,
    exe_res_if.producer     res
);

    logic                   fwd_ok;
    core_pkg::data_t        src_a;
    core_pkg::data_t        src_b;
    core_pkg::data_t        op_b;
    logic [4:0]             shamt;
    core_pkg::data_t        result;

    // Register file lookup
    assign rd_port.rs1 = dec.rs1;
    assign rd_port.rs2 = dec.rs2;

    ////////////////////
    // Operand bypass
    ////////////////////

    // Instruction one ahead still sits in the output register
    assign fwd_ok = res.valid && res.write_rd;
    assign src_a  = (fwd_ok && (res.rd == dec.rs1)) ? res.value : rd_port.rs1_data;
    assign src_b  = (fwd_ok && (res.rd == dec.rs2)) ? res.value : rd_port.rs2_data;

    assign op_b  = dec.use_imm ? dec.imm : src_b;
    assign shamt = op_b[4:0];

    ////////////////////
    // ALU
    ////////////////////

    always_comb begin
        case (dec.func)
            core_pkg::alu_add:    result = src_a + op_b;
            core_pkg::alu_sub:    result = src_a - op_b;
            core_pkg::alu_sll:    result = src_a << shamt;
            core_pkg::alu_slt:    result = {31'b0, $signed(src_a) < $signed(op_b)};
            core_pkg::alu_sltu:   result = {31'b0, src_a < op_b};
            core_pkg::alu_xor:    result = src_a ^ op_b;
            core_pkg::alu_srl:    result = src_a >> shamt;
            core_pkg::alu_sra:    result = $signed(src_a) >>> shamt;
            core_pkg::alu_or:     result = src_a | op_b;
            core_pkg::alu_and:    result = src_a & op_b;
            core_pkg::alu_pass_b: result = op_b;
            default:              result = '0;
        endcase
    end

    // Result register
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= dec.valid;
        end
    end

    always_ff @(posedge clock) begin
        res.illegal  <= dec.illegal;
        res.write_rd <= dec.write_rd;
        res.rd       <= dec.rd;
        res.value    <= result;
    end

endmodule

//--- result_regfile.sv
`timescale 1ns/10ps

module result_regfile #(
    parameter int num_regs = 32
) (
    input  logic                  clock,
    input  logic                  rst_n,
    reg_read_if.provider          rd_port,
    exe_res_if.consumer           res,
    output logic                  commit_valid,
    output logic                  commit_illegal,
    output logic                  commit_write,
    output core_pkg::reg_idx_t    commit_rd,
    output core_pkg::data_t       commit_value
);

    // Array index width, 4 bits for RV32E
    localparam int idx_w = $clog2(num_regs);

    core_pkg::data_t    regs [num_regs];
    logic               wr_en;

    ////////////////////
    // Read ports
    ////////////////////

    // x0 never written, forced to zero here
    assign rd_port.rs1_data = (rd_port.rs1 == '0) ? '0 : regs[rd_port.rs1[idx_w-1:0]];
    assign rd_port.rs2_data = (rd_port.rs2 == '0) ? '0 : regs[rd_port.rs2[idx_w-1:0]];

    ////////////////////
    // Write port
    ////////////////////

    assign wr_en = res.valid && res.write_rd;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            regs[res.rd[idx_w-1:0]] <= res.value;
        end
    end

    // Commit report, same edge as the write
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            commit_valid   <= 1'b0;
            commit_illegal <= 1'b0;
            commit_write   <= 1'b0;
        end else begin
            commit_valid   <= res.valid;
            commit_illegal <= res.valid && res.illegal;
            commit_write   <= wr_en;
        end
    end

    always_ff @(posedge clock) begin
        commit_rd    <= res.rd;
        commit_value <= res.value;
    end

endmodule

//--- core_top.sv
`timescale 1ns/10ps

module core_top #(
    parameter int num_regs = 32    // 16 gives RV32E
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  core_pkg::inst_t       inst,
    output logic                  commit_valid,
    output logic                  commit_illegal,
    output logic                  commit_write,
    output core_pkg::reg_idx_t    commit_rd,
    output core_pkg::data_t       commit_value
);

    // Stage links
    dec_exe_if   dec_exe ();
    exe_res_if   exe_res ();
    reg_read_if  reg_read ();

    // Decode
    inst_decode #(
        .num_regs (num_regs)
    ) u_decode (
        .clock      (clock),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec        (dec_exe.producer)
    );

    // Execute with bypass
    alu_execute u_execute (
        .clock   (clock),
        .rst_n   (rst_n),
        .dec     (dec_exe.consumer),
        .rd_port (reg_read.requester),
        .res     (exe_res.producer)
    );

    // Register file and commit
    result_regfile #(
        .num_regs (num_regs)
    ) u_result (
        .clock          (clock),
        .rst_n          (rst_n),
        .rd_port        (reg_read.provider),
        .res            (exe_res.consumer),
        .commit_valid   (commit_valid),
        .commit_illegal (commit_illegal),
        .commit_write   (commit_write),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 2
) (
    output logic clock,
    output logic rst_n
);

    // Free running clock
    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // Reset low for the first edges, released on an edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

//--- tb_core.sv
`timescale 1ns/10ps

module tb_core;

    localparam int period_ns     = 4;
    localparam int max_vecs      = 64;
    localparam int words_per_vec = 5;
    localparam int vec_words     = max_vecs * words_per_vec;
    // Reset, pipeline fill and drain
    localparam int margin_ns     = 120;

    logic                  clock;
    logic                  rst_n;
    logic                  inst_valid;
    core_pkg::inst_t       inst;
    logic                  commit_valid;
    logic                  commit_illegal;
    logic                  commit_write;
    core_pkg::reg_idx_t    commit_rd;
    core_pkg::data_t       commit_value;

    // Five words per vector as inst, illegal, write, rd and value
    logic [31:0]           vec_mem [vec_words];
    int                    num_vecs;
    logic                  vectors_loaded = 1'b0;
    int                    issue_idx;
    int                    exp_q [$];
    int                    pop_idx;
    int                    check_errors = 0;
    int                    flow_errors  = 0;
    logic [31:0]           rng_state = 32'h2e7f;

    tb_clock_gen #(
        .period_ns    (period_ns),
        .reset_cycles (2)
    ) u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    core_top #(
        .num_regs (32)
    ) u_dut (
        .clock          (clock),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .commit_valid   (commit_valid),
        .commit_illegal (commit_illegal),
        .commit_write   (commit_write),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] next_xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Marks words the file never reached
    function automatic logic [31:0] fill_word(int a);
        return 32'hf111_0000 ^ a;
    endfunction

    // Source fields of one word against the destination field of the word before
    function automatic logic reads_prev_dest(core_pkg::inst_t cur, core_pkg::inst_t prev);
        return (cur[19:15] == prev[11:7]) || (cur[24:20] == prev[11:7]);
    endfunction

    task automatic load_vectors();
        for (int a = 0; a < vec_words; a++) begin
            vec_mem[a] = fill_word(a);
        end
        $readmemh("core_vectors.txt", vec_mem);
        num_vecs = 0;
        while (num_vecs < max_vecs &&
               vec_mem[num_vecs * words_per_vec] !== fill_word(num_vecs * words_per_vec)) begin
            num_vecs++;
        end
    endtask

    task automatic check_value(string name, int idx, core_pkg::data_t got, core_pkg::data_t exp);
        if (got !== exp) begin
            $display("FAILED %s vector %0d: got %h expected %h", name, idx, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_reg(string name, int idx, core_pkg::reg_idx_t got,
                             core_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("FAILED %s vector %0d: got %h expected %h", name, idx, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_flag(string name, int idx, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED %s vector %0d: got %h expected %h", name, idx, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_commit(int idx);
        int base;
        base = idx * words_per_vec;
        check_flag("commit_illegal", idx, commit_illegal, vec_mem[base + 1][0]);
        check_flag("commit_write", idx, commit_write, vec_mem[base + 2][0]);
        check_reg("commit_rd", idx, commit_rd, vec_mem[base + 3][4:0]);
        // Value only matters when a register is written
        if (vec_mem[base + 2][0]) begin
            check_value("commit_value", idx, commit_value, vec_mem[base + 4]);
        end
    endtask

    ////////////////////
    // Scoreboard
    ////////////////////

    // Pop comes before push so a same edge issue never meets its own commit
    always @(posedge clock) begin
        if (rst_n === 1'b1) begin
            if ($isunknown(commit_valid)) begin
                $display("ERROR: commit_valid is unknown after reset");
                flow_errors++;
            end else if (commit_valid) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: a commit arrived with no instruction outstanding");
                    flow_errors++;
                end else begin
                    pop_idx = exp_q.pop_front();
                    check_commit(pop_idx);
                end
            end
            // Word the DUT samples at this edge
            if (inst_valid === 1'b1) begin
                exp_q.push_back(issue_idx);
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        int gap;
        inst_valid = 1'b0;
        inst       = '0;
        issue_idx  = 0;
        load_vectors();
        vectors_loaded = 1'b1;
        if (num_vecs == 0) begin
            $display("ERROR: no vectors were found in core_vectors.txt");
            flow_errors++;
        end else begin
            while (rst_n !== 1'b1) begin
                @(posedge clock);
            end
            for (int i = 0; i < num_vecs; i++) begin
                // Zero to two idle cycles ahead of each word
                rng_state = next_xorshift(rng_state);
                gap = rng_state % 3;
                // Dependent words go back to back to reach the bypass
                if (i > 0 && reads_prev_dest(vec_mem[i * words_per_vec],
                                             vec_mem[(i - 1) * words_per_vec])) begin
                    gap = 0;
                end
                repeat (gap) begin
                    @(posedge clock);
                    inst_valid <= 1'b0;
                end
                @(posedge clock);
                inst_valid <= 1'b1;
                inst       <= vec_mem[i * words_per_vec];
                issue_idx  <= i;
            end
            @(posedge clock);
            inst_valid <= 1'b0;
            // Three stage latency plus slack for stray commits
            repeat (6) @(posedge clock);
            if (exp_q.size() != 0) begin
                $display("ERROR: %0d instructions never committed", exp_q.size());
                flow_errors++;
            end
        end
        $display("Closing: %0d vectors, %0d check errors, %0d flow errors",
                 num_vecs, check_errors, flow_errors);
        if (check_errors == 0 && flow_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    ////////////////////
    // Watchdog
    ////////////////////

    // At most three cycles per vector including gaps
    initial begin
        wait (vectors_loaded);
        #(num_vecs * 3 * period_ns + margin_ns);
        $display("ERROR: watchdog expired before the run completed");
        $display("Closing: %0d vectors, %0d check errors, %0d flow errors, 1 timeout",
                 num_vecs, check_errors, flow_errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- core_vectors.txt
// inst_word illegal write rd value, all hex, one instruction per line
// value is only compared when write is 1
00500093 0 1 01 00000005
FFD00113 0 1 02 FFFFFFFD
800001B7 0 1 03 80000000
00208233 0 1 04 00000002
402082B3 0 1 05 00000008
40100333 0 1 06 FFFFFFFB
001093B3 0 1 07 000000A0
00112433 0 1 08 00000001
001134B3 0 1 09 00000000
0020C533 0 1 0A FFFFFFF8
0011D5B3 0 1 0B 04000000
4011D633 0 1 0C FC000000
0020E6B3 0 1 0D FFFFFFFD
0020F733 0 1 0E 00000005
00112793 0 1 0F 00000001
FFF13813 0 1 10 00000001
FFF0C893 0 1 11 FFFFFFFA
7F00E913 0 1 12 000007F5
0F017993 0 1 13 000000F0
00409A13 0 1 14 00000050
4041DA93 0 1 15 F8000000
01C15B13 0 1 16 0000000F
06400B93 0 1 17 00000064
001B8B93 0 1 17 00000065
017B8C33 0 1 18 000000CA
417C0CB3 0 1 19 00000065
00708013 0 0 00 0000000C
00000D33 0 1 1A 00000000
FFFFFFFF 1 0 1F 00000000
02208233 1 0 04 00000000
40409A13 1 0 14 00000000
01420DB3 0 1 1B 00000052

//--- sources.f
core_pkg.sv
core_if.sv
inst_decode.sv
alu_execute.sv
result_regfile.sv
core_top.sv
tb_clock_gen.sv
tb_core.sv

//--- Bender.yml
package:
  name: core_slice

sources:
  - core_pkg.sv
  - core_if.sv
  - inst_decode.sv
  - alu_execute.sv
  - result_regfile.sv
  - core_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_core.sv
